//--- rtl/mipsPkg.sv
package mipsPkg;

    localparam logic [31:0] resetVector = 32'hbfc00000;

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fnSll  = 6'h00,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOp_e;

    typedef struct packed {
        opcode_e    op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } rType_t;

    typedef struct packed {
        opcode_e     op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instr_u;

    // linkNone marks beq/bne/j, control flow without a register result
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   aluSrcImm;
        aluOp_e aluOp;
        logic   shiftImm;
        logic   linkNone;
    } ctrl_t;

endpackage

//--- rtl/bypassIf.sv
interface bypassIf (
    input logic clk
);
    logic [4:0]  eRd;
    logic        eRegWrite;
    logic        eLoad;
    logic [4:0]  mRd;
    logic        mRegWrite;
    logic        mLoad;
    logic [31:0] mResult;
    logic [4:0]  wRd;
    logic        wRegWrite;
    logic [31:0] wResult;

    modport stage (
        output eRd, eRegWrite, eLoad,
        output mRd, mRegWrite, mLoad, mResult,
        output wRd, wRegWrite, wResult
    );

    modport hazard (
        input clk,
        input eRd, eRegWrite, eLoad,
        input mRd, mRegWrite, mLoad, mResult,
        input wRd, wRegWrite, wResult
    );
endinterface

//--- rtl/fetchStage.sv
module fetchStage #(
    parameter logic [31:0] resetPc = mipsPkg::resetVector
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic        ireqValid,
    output logic [31:0] ireqAddr,
    input  logic        irespDataOk,
    input  logic [31:0] irespData,
    output logic [31:0] pcF,
    output logic [31:0] instrF,
    output logic        fetchValid
);
    logic [31:0] pc;
    logic        reqValid;
    logic        bufValid;
    logic [31:0] bufInstr;
    logic        redirValid;
    logic [31:0] redirTarget;
    logic        respOk;
    logic        accept;

    // no new request while a held instruction waits in the buffer
    assign ireqValid = reqValid && !bufValid;
    assign ireqAddr = pc;
    assign respOk = ireqValid && irespDataOk;
    assign fetchValid = bufValid || respOk;
    assign instrF = bufValid ? bufInstr : irespData;
    assign pcF = pc;
    assign accept = fetchValid && !stall;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= resetPc;
            reqValid <= 1'b0;
            bufValid <= 1'b0;
            redirValid <= 1'b0;
        end else begin
            reqValid <= 1'b1;
            if (accept) begin
                bufValid <= 1'b0;
                redirValid <= 1'b0;
                // the accepted word is the delay slot of a branch still in decode
                if (branchTaken) begin
                    pc <= branchTarget;
                end else if (redirValid) begin
                    pc <= redirTarget;
                end else begin
                    pc <= pc + 32'd4;
                end
            end else begin
                if (respOk) begin
                    bufValid <= 1'b1;
                end
                // branch left decode before its delay slot arrived
                if (!stall && branchTaken) begin
                    redirValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respOk && stall) begin
            bufInstr <= irespData;
        end
        if (!stall && !fetchValid && branchTaken) begin
            redirTarget <= branchTarget;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        ireqValid && !irespDataOk |=> ireqValid && $stable(ireqAddr));
endmodule

//--- rtl/regFile.sv
module regFile (
    input  logic        clk,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];
    logic        writing;

    assign writing = we && (wa != 5'd0);

    always_ff @(posedge clk) begin
        if (writing) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle write is visible to the readers
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : ((writing && wa == ra1) ? wd : regs[ra1]);
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : ((writing && wa == ra2) ? wd : regs[ra2]);
endmodule

//--- rtl/decodeStage.sv
module decodeStage (
    input  mipsPkg::instr_u instr,
    input  logic [31:0]     pc,
    input  logic [31:0]     rsVal,
    input  logic [31:0]     rtVal,
    output mipsPkg::ctrl_t  ctrl,
    output logic [4:0]      rs,
    output logic [4:0]      rt,
    output logic [4:0]      dest,
    output logic [4:0]      shamt,
    output logic [31:0]     imm,
    output logic            branchTaken,
    output logic [31:0]     branchTarget,
    output logic            usesRs,
    output logic            usesRt
);
    import mipsPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] immSext;
    logic [31:0] immZext;
    logic        operandsEq;

    assign pcPlus4 = pc + 32'd4;
    assign immSext = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
    assign immZext = {16'd0, instr.iType.imm16};
    assign rs = instr.iType.rs;
    assign rt = instr.iType.rt;
    assign shamt = instr.rType.shamt;
    assign operandsEq = (rsVal == rtVal);

    always_comb begin
        ctrl = '0;
        dest = instr.iType.rt;
        imm = immSext;
        usesRs = 1'b1;
        usesRt = 1'b0;
        branchTaken = 1'b0;
        branchTarget = pcPlus4 + {immSext[29:0], 2'b00};
        case (instr.rType.op)
            opSpecial: begin
                dest = instr.rType.rd;
                usesRt = 1'b1;
                ctrl.regWrite = 1'b1;
                case (instr.rType.funct)
                    fnAddu: ctrl.aluOp = aluAdd;
                    fnSubu: ctrl.aluOp = aluSub;
                    fnAnd: ctrl.aluOp = aluAnd;
                    fnOr: ctrl.aluOp = aluOr;
                    fnXor: ctrl.aluOp = aluXor;
                    fnSlt: ctrl.aluOp = aluSlt;
                    fnSll: begin
                        ctrl.aluOp = aluSll;
                        ctrl.shiftImm = 1'b1;
                        usesRs = 1'b0;
                    end
                    default: begin
                        ctrl = '0;
                        usesRs = 1'b0;
                        usesRt = 1'b0;
                    end
                endcase
            end
            opAddiu, opAndi, opOri, opLui, opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead = (instr.iType.op == opLw);
                if (instr.iType.op == opAndi) begin
                    ctrl.aluOp = aluAnd;
                    imm = immZext;
                end else if (instr.iType.op == opOri) begin
                    ctrl.aluOp = aluOr;
                    imm = immZext;
                end else if (instr.iType.op == opLui) begin
                    ctrl.aluOp = aluLui;
                    imm = {instr.iType.imm16, 16'd0};
                    usesRs = 1'b0;
                end
            end
            opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                usesRt = 1'b1;
            end
            opBeq, opBne: begin
                ctrl.linkNone = 1'b1;
                usesRt = 1'b1;
                branchTaken = (instr.iType.op == opBeq) ? operandsEq : !operandsEq;
            end
            opJ: begin
                ctrl.linkNone = 1'b1;
                usesRs = 1'b0;
                branchTaken = 1'b1;
                branchTarget = {pcPlus4[31:28], instr[25:0], 2'b00};
            end
            default: begin
                usesRs = 1'b0;
            end
        endcase
    end
endmodule

//--- rtl/executeStage.sv
module executeStage (
    input  mipsPkg::ctrl_t ctrl,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  logic [31:0]    imm,
    input  logic [4:0]     shamt,
    output logic [31:0]    result
);
    import mipsPkg::*;

    logic [31:0] bOp;
    logic [4:0]  shiftBy;

    assign bOp = ctrl.aluSrcImm ? imm : b;
    // variable shifts would take the amount from rs
    assign shiftBy = ctrl.shiftImm ? shamt : a[4:0];

    always_comb begin
        case (ctrl.aluOp)
            aluAdd: begin
                result = a + bOp;
            end
            aluSub: begin
                result = a - bOp;
            end
            aluAnd: begin
                result = a & bOp;
            end
            aluOr: begin
                result = a | bOp;
            end
            aluXor: begin
                result = a ^ bOp;
            end
            aluSlt: begin
                result = {31'd0, $signed(a) < $signed(bOp)};
            end
            aluSll: begin
                result = bOp << shiftBy;
            end
            // decode already placed the upper half
            aluLui: begin
                result = bOp;
            end
            default: begin
                result = 32'd0;
            end
        endcase
    end
endmodule

//--- rtl/memoryStage.sv
module memoryStage (
    input  logic           clk,
    input  logic           resetn,
    input  mipsPkg::ctrl_t ctrl,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic           dreqValid,
    output logic           dreqWrite,
    output logic [31:0]    dreqAddr,
    output logic [31:0]    dreqWdata,
    input  logic           drespDataOk,
    input  logic [31:0]    drespRdata,
    output logic [31:0]    rdata,
    output logic           memBusy
);
    logic memOp;

    // the stage only advances on dataOk, so each lw/sw asks once
    assign memOp = ctrl.memRead || ctrl.memWrite;
    assign dreqValid = memOp;
    assign dreqWrite = ctrl.memWrite;
    assign dreqAddr = addr;
    assign dreqWdata = wdata;
    assign rdata = drespRdata;
    assign memBusy = memOp && !drespDataOk;

    // address comes from the execute adder
    assert property (@(posedge clk) disable iff (!resetn)
        dreqValid |-> dreqAddr[1:0] == 2'b00);

    assert property (@(posedge clk) disable iff (!resetn)
        dreqValid && !drespDataOk |=> dreqValid && $stable(dreqAddr) && $stable(dreqWdata));
endmodule

//--- rtl/hazardUnit.sv
module hazardUnit (
    bypassIf.hazard bp,
    input  logic [4:0]  rsD,
    input  logic [4:0]  rtD,
    input  logic        usesRs,
    input  logic        usesRt,
    input  logic        isBranchD,
    input  logic [4:0]  rsE,
    input  logic [4:0]  rtE,
    input  logic [31:0] rsValD,
    input  logic [31:0] rtValD,
    input  logic [31:0] rsValE,
    input  logic [31:0] rtValE,
    output logic [31:0] fwdRsD,
    output logic [31:0] fwdRtD,
    output logic [31:0] fwdRsE,
    output logic [31:0] fwdRtE,
    output logic        stallD
);
    logic [4:0] mSrc;
    logic [4:0] wSrc;
    logic       rsHitE;
    logic       rtHitE;
    logic       rsLoadM;
    logic       rtLoadM;

    // a load in memory has no data yet
    assign mSrc = (bp.mRegWrite && !bp.mLoad) ? bp.mRd : 5'd0;
    assign wSrc = bp.wRegWrite ? bp.wRd : 5'd0;

    function automatic logic [31:0] forward(
        input logic [4:0]  src,
        input logic [31:0] raw,
        input logic [4:0]  mRd,
        input logic [31:0] mVal,
        input logic [4:0]  wRd,
        input logic [31:0] wVal
    );
        if (src == 5'd0) begin
            return raw;
        end else if (src == mRd) begin
            return mVal;
        end else if (src == wRd) begin
            return wVal;
        end
        return raw;
    endfunction

    assign fwdRsD = forward(rsD, rsValD, mSrc, bp.mResult, wSrc, bp.wResult);
    assign fwdRtD = forward(rtD, rtValD, mSrc, bp.mResult, wSrc, bp.wResult);
    assign fwdRsE = forward(rsE, rsValE, mSrc, bp.mResult, wSrc, bp.wResult);
    assign fwdRtE = forward(rtE, rtValE, mSrc, bp.mResult, wSrc, bp.wResult);

    assign rsHitE = usesRs && bp.eRegWrite && bp.eRd != 5'd0 && bp.eRd == rsD;
    assign rtHitE = usesRt && bp.eRegWrite && bp.eRd != 5'd0 && bp.eRd == rtD;
    assign rsLoadM = usesRs && bp.mLoad && bp.mRegWrite && bp.mRd != 5'd0 && bp.mRd == rsD;
    assign rtLoadM = usesRt && bp.mLoad && bp.mRegWrite && bp.mRd != 5'd0 && bp.mRd == rtD;

    // branches compare in decode, so they wait longer than other consumers
    assign stallD = (bp.eLoad && (rsHitE || rtHitE))
        || (isBranchD && (rsHitE || rtHitE || rsLoadM || rtLoadM));

    // register 0 reads as zero through regFile and every bypass path
    assert property (@(posedge bp.clk)
        rsD == 5'd0 |-> fwdRsD == 32'd0);

    assert property (@(posedge bp.clk)
        rtD == 5'd0 |-> fwdRtD == 32'd0);
endmodule

//--- rtl/MipsCore.sv
module MipsCore #(
    parameter logic [31:0] resetPc = mipsPkg::resetVector
) (
    input  logic        clk,
    input  logic        resetn,
    output logic        ireqValid,
    output logic [31:0] ireqAddr,
    input  logic        irespDataOk,
    input  logic [31:0] irespData,
    output logic        dreqValid,
    output logic        dreqWrite,
    output logic [31:0] dreqAddr,
    output logic [31:0] dreqWdata,
    input  logic        drespDataOk,
    input  logic [31:0] drespRdata,
    output logic [31:0] debugPc,
    output logic        debugWen,
    output logic [4:0]  debugRd,
    output logic [31:0] debugData
);
    import mipsPkg::*;

    logic        stallD;
    logic        memBusy;
    logic        stallF;
    logic [31:0] pcF;
    logic [31:0] instrF;
    logic        fetchValid;
    logic        branchTaken;
    logic [31:0] branchTarget;

    instr_u      instrD;
    logic [31:0] pcD;
    ctrl_t       ctrlD;
    logic [4:0]  rsD, rtD, destD, shamtD;
    logic [31:0] immD, rsValD, rtValD, fwdRsD, fwdRtD;
    logic        usesRs, usesRt;

    ctrl_t       ctrlE;
    logic [4:0]  rsE, rtE, destE, shamtE;
    logic [31:0] pcE, immE, rsValE, rtValE, fwdRsE, fwdRtE, resultE;

    ctrl_t       ctrlM;
    logic [4:0]  destM;
    logic [31:0] pcM, aluM, storeM, rdataM;

    ctrl_t       ctrlW;
    logic [4:0]  destW;
    logic [31:0] pcW, aluW, loadW, resultW;

    assign stallF = stallD || memBusy;

    fetchStage #(.resetPc(resetPc)) fetch_i (
        .clk, .resetn, .stall(stallF), .branchTaken, .branchTarget,
        .ireqValid, .ireqAddr, .irespDataOk, .irespData,
        .pcF, .instrF, .fetchValid
    );

    regFile regs_i (
        .clk, .ra1(rsD), .ra2(rtD), .wa(destW), .we(ctrlW.regWrite), .wd(resultW),
        .rd1(rsValD), .rd2(rtValD)
    );

    decodeStage decode_i (
        .instr(instrD), .pc(pcD), .rsVal(fwdRsD), .rtVal(fwdRtD),
        .ctrl(ctrlD), .rs(rsD), .rt(rtD), .dest(destD), .shamt(shamtD), .imm(immD),
        .branchTaken, .branchTarget, .usesRs, .usesRt
    );

    executeStage execute_i (
        .ctrl(ctrlE), .a(fwdRsE), .b(fwdRtE), .imm(immE), .shamt(shamtE), .result(resultE)
    );

    memoryStage memory_i (
        .clk, .resetn, .ctrl(ctrlM), .addr(aluM), .wdata(storeM),
        .dreqValid, .dreqWrite, .dreqAddr, .dreqWdata, .drespDataOk, .drespRdata,
        .rdata(rdataM), .memBusy
    );

    bypassIf bp (.clk);

    assign bp.eRd = destE;
    assign bp.eRegWrite = ctrlE.regWrite;
    assign bp.eLoad = ctrlE.memRead;
    assign bp.mRd = destM;
    assign bp.mRegWrite = ctrlM.regWrite;
    assign bp.mLoad = ctrlM.memRead;
    assign bp.mResult = aluM;
    assign bp.wRd = destW;
    assign bp.wRegWrite = ctrlW.regWrite;
    assign bp.wResult = resultW;

    hazardUnit hazard_i (
        .bp, .rsD, .rtD, .usesRs, .usesRt, .isBranchD(ctrlD.linkNone), .rsE, .rtE,
        .rsValD, .rtValD, .rsValE, .rtValE,
        .fwdRsD, .fwdRtD, .fwdRsE, .fwdRtE, .stallD
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            instrD <= '0;
            ctrlE <= '0;
            ctrlM <= '0;
            ctrlW <= '0;
        end else begin
            if (!stallF) begin
                instrD <= fetchValid ? instrF : '0;
            end
            if (!memBusy) begin
                ctrlE <= stallD ? '0 : ctrlD;
                ctrlM <= ctrlE;
            end
            // writeback must not see the waiting memory op twice
            ctrlW <= memBusy ? '0 : ctrlM;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallF) begin
            pcD <= pcF;
        end
        if (memBusy) begin
            // keep operands whose source retires while execute is frozen
            rsValE <= fwdRsE;
            rtValE <= fwdRtE;
        end else if (!stallD) begin
            pcE <= pcD;
            rsE <= rsD;
            rtE <= rtD;
            destE <= destD;
            shamtE <= shamtD;
            immE <= immD;
            rsValE <= fwdRsD;
            rtValE <= fwdRtD;
        end
        if (!memBusy) begin
            pcM <= pcE;
            destM <= destE;
            aluM <= resultE;
            storeM <= fwdRtE;
            pcW <= pcM;
            destW <= destM;
            aluW <= aluM;
            loadW <= rdataM;
        end
    end

    assign resultW = ctrlW.memRead ? loadW : aluW;

    assign debugPc = pcW;
    assign debugWen = ctrlW.regWrite && (destW != 5'd0);
    assign debugRd = destW;
    assign debugData = resultW;
endmodule

//--- verif/MipsCoreTb.sv
module MipsCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] base = 32'hbfc00000;
    localparam int period = 40;
    localparam int progWords = 40;
    // each instruction can wait on both buses and a stall, 100 cycles is ample
    localparam int maxCycles = progWords * 100;

    localparam int fnSll = 'h00;
    localparam int fnAddu = 'h21;
    localparam int fnSubu = 'h23;
    localparam int fnAnd = 'h24;
    localparam int fnOr = 'h25;
    localparam int fnXor = 'h26;
    localparam int fnSlt = 'h2a;
    localparam int opBeq = 'h04;
    localparam int opBne = 'h05;
    localparam int opAddiu = 'h09;
    localparam int opAndi = 'h0c;
    localparam int opOri = 'h0d;
    localparam int opLui = 'h0f;
    localparam int opLw = 'h23;
    localparam int opSw = 'h2b;

    logic        clk;
    logic        resetn;
    logic        ireqValid;
    logic [31:0] ireqAddr;
    logic        irespDataOk;
    logic [31:0] irespData;
    logic        dreqValid;
    logic        dreqWrite;
    logic [31:0] dreqAddr;
    logic [31:0] dreqWdata;
    logic        drespDataOk;
    logic [31:0] drespRdata;
    logic [31:0] debugPc;
    logic        debugWen;
    logic [4:0]  debugRd;
    logic [31:0] debugData;
    logic        storeDone;
    logic        firstReq;

    logic [31:0] rom [64];
    logic [31:0] ram [256];
    logic [31:0] goldPc [32];
    logic [4:0]  goldRd [32];
    logic [31:0] goldData [32];
    string       goldName [32];
    logic [31:0] storeAddr [4];
    logic [31:0] storeData [4];
    string       section;
    int          progLen = 0;
    int          commitTotal = 0;
    int          storeTotal = 0;
    int          commitIdx;
    int          storeIdx;
    int          errors = 0;
    int          iDelay;
    int          dDelay;
    integer      seed = 32'hc5adf3f8;

    MipsCore #(.resetPc(base)) dut_i (.*);

    function automatic logic [31:0] rType(input int fn, rs, rt, rd, sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] iType(input int op, rs, rt, imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] wordAddr(input int w);
        return base + 32'(w * 4);
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - base;
        if (off < 32'(progLen * 4)) begin
            return rom[off[7:2]];
        end
        return 32'h0;
    endfunction

    // rd 0 means the instruction must not commit
    task automatic addInstr(input logic [31:0] word, input int rd, input logic [31:0] data);
        rom[progLen[5:0]] = word;
        if (rd != 0) begin
            goldPc[commitTotal[4:0]] = wordAddr(progLen);
            goldRd[commitTotal[4:0]] = 5'(rd);
            goldData[commitTotal[4:0]] = data;
            goldName[commitTotal[4:0]] = section;
            commitTotal++;
        end
        progLen++;
    endtask

    task automatic addStore(input logic [31:0] addr, input logic [31:0] data);
        storeAddr[storeTotal[1:0]] = addr;
        storeData[storeTotal[1:0]] = data;
        storeTotal++;
    endtask

    task automatic loadProgram();
        section = "alu chain";
        addInstr(iType(opAddiu, 0, 1, 5), 1, 32'd5);
        addInstr(iType(opAddiu, 1, 2, 7), 2, 32'd12);
        addInstr(rType(fnAddu, 1, 2, 3, 0), 3, 32'd17);
        addInstr(rType(fnSubu, 3, 1, 4, 0), 4, 32'd12);
        addInstr(iType(opLui, 0, 5, 'h1234), 5, 32'h12340000);
        addInstr(iType(opOri, 5, 5, 'h5678), 5, 32'h12345678);
        addInstr(iType(opAndi, 5, 6, 'hff0f), 6, 32'h00005608);
        addInstr(rType(fnXor, 5, 6, 7, 0), 7, 32'h12340070);
        addInstr(rType(fnOr, 4, 1, 8, 0), 8, 32'd13);
        addInstr(rType(fnAnd, 3, 2, 9, 0), 9, 32'd0);
        addInstr(rType(fnSlt, 4, 3, 10, 0), 10, 32'd1);
        addInstr(iType(opAddiu, 0, 11, -3), 11, 32'hfffffffd);
        addInstr(rType(fnSlt, 11, 1, 12, 0), 12, 32'd1);
        addInstr(rType(fnSlt, 1, 11, 13, 0), 13, 32'd0);
        addInstr(rType(fnSll, 0, 5, 14, 4), 14, 32'h23456780);
        section = "zero register";
        addInstr(iType(opAddiu, 1, 0, 9), 0, 32'd0);
        addInstr(rType(fnAddu, 0, 1, 15, 0), 15, 32'd5);
        section = "load store";
        addInstr(iType(opSw, 0, 5, 'h40), 0, 32'd0);
        addStore(32'h40, 32'h12345678);
        addInstr(iType(opLw, 0, 16, 'h40), 16, 32'h12345678);
        addInstr(rType(fnAddu, 16, 1, 17, 0), 17, 32'h1234567d);
        addInstr(iType(opSw, 0, 17, 'h44), 0, 32'd0);
        addStore(32'h44, 32'h1234567d);
        addInstr(iType(opLw, 0, 18, 'h44), 18, 32'h1234567d);
        section = "branches";
        addInstr(iType(opAddiu, 1, 19, 0), 19, 32'd5);
        addInstr(iType(opBeq, 19, 1, 2), 0, 32'd0);
        addInstr(iType(opAddiu, 0, 20, 'h11), 20, 32'h11);
        // skipped by the taken beq
        addInstr(iType(opAddiu, 0, 21, 'h22), 0, 32'd0);
        addInstr(iType(opBne, 1, 1, 5), 0, 32'd0);
        addInstr(iType(opAddiu, 0, 22, 'h33), 22, 32'h33);
        addInstr(iType(opAddiu, 0, 23, 'h44), 23, 32'h44);
        addInstr(iType(opLw, 0, 24, 'h40), 24, 32'h12345678);
        addInstr(iType(opBne, 24, 1, 2), 0, 32'd0);
        addInstr(rType(fnAddu, 24, 1, 25, 0), 25, 32'h1234567d);
        addInstr(iType(opAddiu, 0, 26, 'h55), 0, 32'd0);
        addInstr(jType(wordAddr(36)), 0, 32'd0);
        addInstr(iType(opAddiu, 0, 27, 'h66), 27, 32'h66);
        addInstr(iType(opAddiu, 0, 28, 'h77), 0, 32'd0);
        addInstr(rType(fnAddu, 27, 25, 29, 0), 29, 32'h123456e3);
        addInstr(iType(opSw, 0, 29, 'h48), 0, 32'd0);
        addStore(32'h48, 32'h123456e3);
        // park the core in a jump loop with a nop delay slot
        addInstr(jType(wordAddr(38)), 0, 32'd0);
        addInstr(rType(fnSll, 0, 0, 0, 0), 0, 32'd0);
    endtask

    task automatic finishRun();
        $display("commits %0d of %0d, stores %0d of %0d, errors %0d",
            commitIdx, commitTotal, storeIdx, storeTotal, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // both slaves share one process so the random draws keep a fixed order
    always @(posedge clk) begin
        if (!resetn) begin
            irespDataOk <= 1'b0;
            drespDataOk <= 1'b0;
            iDelay = -1;
            dDelay = -1;
        end else begin
            if (irespDataOk) begin
                irespDataOk <= 1'b0;
                iDelay = -1;
            end else if (ireqValid) begin
                if (iDelay < 0) begin
                    iDelay = $random(seed) & 3;
                end
                if (iDelay == 0) begin
                    irespDataOk <= 1'b1;
                    irespData <= fetchWord(ireqAddr);
                end else begin
                    iDelay--;
                end
            end
            if (drespDataOk) begin
                drespDataOk <= 1'b0;
                dDelay = -1;
            end else if (dreqValid) begin
                if (dDelay < 0) begin
                    dDelay = $random(seed) & 3;
                end
                if (dDelay == 0) begin
                    drespDataOk <= 1'b1;
                    drespRdata <= ram[dreqAddr[9:2]];
                    if (dreqWrite) begin
                        ram[dreqAddr[9:2]] = dreqWdata;
                    end
                end else begin
                    dDelay--;
                end
            end
        end
    end

    assign storeDone = dreqValid && dreqWrite && drespDataOk;

    always @(posedge clk) begin
        if (!resetn) begin
            commitIdx <= 0;
            storeIdx <= 0;
            firstReq <= 1'b1;
        end else begin
            if (debugWen && commitIdx < commitTotal) begin
                commitIdx <= commitIdx + 1;
            end
            if (storeDone && storeIdx < storeTotal) begin
                storeIdx <= storeIdx + 1;
            end
            if (ireqValid) begin
                firstReq <= 1'b0;
            end
        end
    end

    resetQuiet: assert property (@(posedge clk) disable iff (!resetn)
        firstReq |-> !dreqValid && !debugWen)
    else begin
        errors++;
        $display("data request or commit seen before the first fetch");
    end

    reqAfterReset: assert property (@(posedge clk) $rose(resetn) |=> ireqValid)
    else begin
        errors++;
        $display("no instruction request in the first cycle after reset");
    end

    firstFetch: assert property (@(posedge clk) disable iff (!resetn)
        firstReq && ireqValid |-> ireqAddr == base)
    else begin
        errors++;
        $display("FAIL reset: first ireqAddr expected %h actual %h", base, ireqAddr);
    end

    extraCommit: assert property (@(posedge clk) disable iff (!resetn)
        debugWen |-> commitIdx < commitTotal)
    else begin
        errors++;
        $display("unexpected commit of r%0d at pc %h after the last one", debugRd, debugPc);
    end

    commitPc: assert property (@(posedge clk) disable iff (!resetn)
        debugWen && commitIdx < commitTotal |-> debugPc == goldPc[commitIdx[4:0]])
    else begin
        errors++;
        $display("FAIL %s: commit %0d pc expected %h actual %h",
            goldName[commitIdx[4:0]], commitIdx, goldPc[commitIdx[4:0]], debugPc);
    end

    commitRd: assert property (@(posedge clk) disable iff (!resetn)
        debugWen && commitIdx < commitTotal |-> debugRd == goldRd[commitIdx[4:0]])
    else begin
        errors++;
        $display("FAIL %s: commit %0d rd expected %0d actual %0d",
            goldName[commitIdx[4:0]], commitIdx, goldRd[commitIdx[4:0]], debugRd);
    end

    commitData: assert property (@(posedge clk) disable iff (!resetn)
        debugWen && commitIdx < commitTotal |-> debugData == goldData[commitIdx[4:0]])
    else begin
        errors++;
        $display("FAIL %s: commit %0d data expected %h actual %h",
            goldName[commitIdx[4:0]], commitIdx, goldData[commitIdx[4:0]], debugData);
    end

    extraStore: assert property (@(posedge clk) disable iff (!resetn)
        storeDone |-> storeIdx < storeTotal)
    else begin
        errors++;
        $display("unexpected store to %h after the last one", dreqAddr);
    end

    storeAddrOk: assert property (@(posedge clk) disable iff (!resetn)
        storeDone && storeIdx < storeTotal |-> dreqAddr == storeAddr[storeIdx[1:0]])
    else begin
        errors++;
        $display("FAIL store: store %0d address expected %h actual %h",
            storeIdx, storeAddr[storeIdx[1:0]], dreqAddr);
    end

    storeDataOk: assert property (@(posedge clk) disable iff (!resetn)
        storeDone && storeIdx < storeTotal |-> dreqWdata == storeData[storeIdx[1:0]])
    else begin
        errors++;
        $display("FAIL store: store %0d data expected %h actual %h",
            storeIdx, storeData[storeIdx[1:0]], dreqWdata);
    end

    initial begin
        resetn <= 1'b0;
        irespDataOk <= 1'b0;
        irespData <= 32'd0;
        drespDataOk <= 1'b0;
        drespRdata <= 32'd0;
        for (int i = 0; i < 256; i++) begin
            ram[i[7:0]] = 32'hda7a0000 | 32'(i * 4);
        end
        loadProgram();
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        wait (commitIdx == commitTotal && storeIdx == storeTotal);
        // room for a duplicated or late commit to show up
        repeat (40) @(posedge clk);
        finishRun();
    end

    initial begin
        #(maxCycles * period);
        errors++;
        $display("timeout after %0d cycles with commits or stores still missing", maxCycles);
        finishRun();
    end
endmodule

//--- sources.f
rtl/mipsPkg.sv
rtl/bypassIf.sv
rtl/fetchStage.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/hazardUnit.sv
rtl/MipsCore.sv
verif/MipsCoreTb.sv

//--- Makefile
TOP       ?= MipsCoreTb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
FILELIST  ?= sources.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS      ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
